// File: filelist.f
+incdir+verification
src/tcdm_pkg.sv
src/amo_pkg.sv
src/resp_fifo.sv
src/amo_alu.sv
src/lrsc_reservation.sv
src/tcdm_adapter.sv
src/sram_bank.sv
src/tcdm_bank_top.sv
verification/tcdm_bank_tb.sv

// File: src/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu import amo_pkg::*; (
  input  amo_op_t     op_i,
  input  logic [31:0] mem_word_i,
  input  logic [31:0] operand_i,
  output logic [31:0] result_o
);

  logic        is_signed;
  logic        is_sub;
  logic [33:0] opa_ext;
  logic [33:0] opb_ext;
  logic [33:0] adder_sum;
  logic        mem_lt_op;

  // Signed compare needs sign extension, unsigned zero extension
  assign is_signed = (op_i == AmoMax) || (op_i == AmoMin);
  assign is_sub    = op_i inside {AmoMax, AmoMaxu, AmoMin, AmoMinu};

  assign opa_ext = {{2{is_signed & mem_word_i[31]}}, mem_word_i};
  assign opb_ext = {{2{is_signed & operand_i[31]}}, operand_i};

  // One adder for add and for compare
  // Subtract by inverting and feeding carry in
  assign adder_sum = opa_ext + (is_sub ? ~opb_ext : opb_ext) + {33'd0, is_sub};

  // Negative difference means memory word is smaller
  assign mem_lt_op = adder_sum[33];

  always_comb begin
    unique case (op_i)
      AmoSwap: result_o = operand_i;
      AmoAdd:  result_o = adder_sum[31:0];
      AmoAnd:  result_o = mem_word_i & operand_i;
      AmoOr:   result_o = mem_word_i | operand_i;
      AmoXor:  result_o = mem_word_i ^ operand_i;
      // Max keeps the larger one
      AmoMax,
      AmoMaxu: result_o = mem_lt_op ? operand_i : mem_word_i;
      // Min keeps the smaller one
      AmoMin,
      AmoMinu: result_o = mem_lt_op ? mem_word_i : operand_i;
      default: result_o = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/amo_pkg.sv
`default_nettype none

// Atomic memory operation encoding
package amo_pkg;

  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_t;

  // True for ops that read, modify and write back a word
  function automatic logic is_rmw(amo_op_t op);
    return op inside {AmoSwap, AmoAdd, AmoAnd, AmoOr, AmoXor,
                      AmoMax, AmoMaxu, AmoMin, AmoMinu};
  endfunction

endpackage

`default_nettype wire

// File: src/lrsc_reservation.sv
`timescale 1ns/1ps
`default_nettype none

module lrsc_reservation import tcdm_pkg::*; import amo_pkg::*; #(
  parameter int unsigned AddrWidth  = 10,
  parameter bit          LrScEnable = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 accept_i,
  input  amo_op_t              op_i,
  input  logic                 write_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  core_id_t             core_i,
  output logic                 sc_success_o,
  output logic                 sc_pending_o,
  output logic                 sc_result_o
);

  // Reservation state
  logic                 res_valid_q, res_valid_d;
  logic [AddrWidth-1:0] res_addr_q, res_addr_d;
  core_id_t             res_core_q, res_core_d;

  logic holder;
  logic addr_hit;

  assign holder   = res_valid_q && (res_core_q == core_i);
  assign addr_hit = (res_addr_q == addr_i);

  always_comb begin
    res_valid_d  = res_valid_q;
    res_addr_d   = res_addr_q;
    res_core_d   = res_core_q;
    sc_success_o = 1'b0;
    if (accept_i && LrScEnable) begin
      // LR only takes a free slot or renews its own
      if (op_i == AmoLr && (!res_valid_q || holder)) begin
        res_valid_d = 1'b1;
        res_addr_d  = addr_i;
        res_core_d  = core_i;
      end
      // Store or RMW from someone else breaks it
      if (res_valid_q && !holder && addr_hit &&
          (is_rmw(op_i) || (write_i && op_i != AmoSc))) begin
        res_valid_d = 1'b0;
      end
      // SC from holder always consumes it
      if (op_i == AmoSc && holder) begin
        res_valid_d  = 1'b0;
        sc_success_o = addr_hit;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q  <= 1'b0;
      sc_pending_o <= 1'b0;
      sc_result_o  <= 1'b0;
    end else begin
      res_valid_q  <= res_valid_d;
      // SC outcome seen one cycle later with the read data
      sc_pending_o <= LrScEnable && accept_i && (op_i == AmoSc);
      sc_result_o  <= sc_success_o;
    end
  end

  // Reserved address and owning core
  always_ff @(posedge clk_i) begin
    res_addr_q <= res_addr_d;
    res_core_q <= res_core_d;
  end

endmodule

`default_nettype wire

// File: src/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic valid_o,
  output logic full_o,
  output logic empty_o
);

  // Two storage slots
  T           mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  logic do_push;
  logic do_pop;

  assign empty_o = (count_q == 2'd0);
  assign full_o  = (count_q == 2'd2);

  // Fall-through path when nothing is stored
  assign valid_o = !empty_o || push_i;
  assign data_o  = empty_o ? data_i : mem_q[rd_ptr_q];

  // Push consumed straight through does not touch storage
  assign do_push = push_i && !(empty_o && pop_i) && (!full_o || pop_i);
  assign do_pop  = pop_i && !empty_o;

  // ------------------------------------------------
  // Pointers and fill count
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (do_pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, do_push} - {1'b0, do_pop};
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: src/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
  parameter  int unsigned NumWords  = 1024,
  localparam int unsigned AddrWidth = $clog2(NumWords)
) (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 write_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [31:0]          wdata_i,
  input  logic [3:0]           be_i,
  output logic [31:0]          rdata_o
);

  // Word array, starts cleared
  logic [31:0] mem_q [NumWords] = '{default: '0};

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      // Old word comes back for reads and writes alike
      rdata_o <= mem_q[addr_i];
      if (write_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/tcdm_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module tcdm_adapter import tcdm_pkg::*; import amo_pkg::*; #(
  parameter int unsigned AddrWidth   = 10,
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request side
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [AddrWidth-1:0] req_addr_i,
  input  amo_op_t              req_amo_i,
  input  logic                 req_write_i,
  input  logic [31:0]          req_wdata_i,
  input  logic [3:0]           req_be_i,
  input  tcdm_meta_t           req_meta_i,
  // Response side
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  // FIFO control
  output logic                 meta_push_o,
  input  logic                 meta_valid_i,
  output logic                 rdata_push_o,
  output logic [31:0]          rdata_o,
  input  logic                 rdata_valid_i,
  input  logic                 rdata_full_i,
  input  logic                 rdata_empty_i,
  output logic                 pop_o,
  // SRAM side
  output logic                 mem_req_o,
  output logic                 mem_write_o,
  output logic [AddrWidth-1:0] mem_addr_o,
  output logic [31:0]          mem_wdata_o,
  output logic [3:0]           mem_be_o,
  input  logic [31:0]          mem_rdata_i
);

  typedef enum logic [1:0] {Idle, DoAmo, WriteBack} state_e;

  state_e               state_q, state_d;
  logic                 accept;
  logic                 gnt_q;
  logic                 wb_en;
  logic [31:0]          wb_data;
  amo_op_t              amo_op_q;
  logic [31:0]          amo_operand_q;
  logic [AddrWidth-1:0] amo_addr_q;
  logic [31:0]          amo_result, amo_result_q;
  logic                 sc_success_d, sc_pending_q, sc_result_q;

  // ------------------------------------------------
  // Handshakes
  // ------------------------------------------------
  // Only take requests with no response parked and no AMO running
  assign req_ready_o = (state_q == Idle) && rdata_empty_i && !rdata_full_i;
  assign accept      = req_valid_i && req_ready_o;
  assign meta_push_o = accept;
  // Response needs both halves
  assign rsp_valid_o = meta_valid_i && rdata_valid_i;
  assign pop_o       = rsp_valid_o && rsp_ready_i;

  // Read data lands one cycle after each access, write-back excluded
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= mem_req_o && !wb_en;
    end
  end
  assign rdata_push_o = gnt_q;
  // SC answers 0 on success, 1 on failure
  assign rdata_o = sc_pending_q ? {31'd0, !sc_result_q} : mem_rdata_i;

  lrsc_reservation #(
    .AddrWidth  (AddrWidth),
    .LrScEnable (LrScEnable)
  ) i_lrsc_reservation (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .op_i         (req_amo_i),
    .write_i      (req_write_i),
    .addr_i       (req_addr_i),
    .core_i       (req_meta_i.core_id),
    .sc_success_o (sc_success_d),
    .sc_pending_o (sc_pending_q),
    .sc_result_o  (sc_result_q)
  );

  // ------------------------------------------------
  // Atomics
  // ------------------------------------------------
  amo_alu i_amo_alu (
    .op_i       (amo_op_q),
    .mem_word_i (mem_rdata_i),
    .operand_i  (amo_operand_q),
    .result_o   (amo_result)
  );

  // Write-back cycle depends on the optional result register
  assign wb_en   = (state_q == WriteBack) || (state_q == DoAmo && !RegisterAmo);
  assign wb_data = RegisterAmo ? amo_result_q : amo_result;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:      if (accept && is_rmw(req_amo_i)) state_d = DoAmo;
      DoAmo:     state_d = RegisterAmo ? WriteBack : Idle;
      WriteBack: state_d = Idle;
      default:   state_d = Idle;
    endcase
  end

  // SRAM port, write-back claims it with a full word
  // An SC writes only when it succeeds
  always_comb begin
    mem_req_o   = accept;
    mem_write_o = (req_write_i && (req_amo_i != AmoSc)) || sc_success_d;
    mem_addr_o  = req_addr_i;
    mem_wdata_o = req_wdata_i;
    mem_be_o    = req_be_i;
    if (wb_en) begin
      mem_req_o   = 1'b1;
      mem_write_o = 1'b1;
      mem_addr_o  = amo_addr_q;
      mem_wdata_o = wb_data;
      mem_be_o    = 4'hF;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Op, operand and address of the running AMO
  always_ff @(posedge clk_i) begin
    if (accept && is_rmw(req_amo_i)) begin
      amo_op_q      <= req_amo_i;
      amo_operand_q <= req_wdata_i;
      amo_addr_q    <= req_addr_i;
    end
    if (state_q == DoAmo) begin
      amo_result_q <= amo_result;
    end
  end

endmodule

`default_nettype wire

// File: src/tcdm_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_top import tcdm_pkg::*; import amo_pkg::*; #(
  parameter int unsigned AddrWidth   = 10,
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request port
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [AddrWidth-1:0] req_addr_i,
  input  amo_op_t              req_amo_i,
  input  logic                 req_write_i,
  input  logic [31:0]          req_wdata_i,
  input  logic [3:0]           req_be_i,
  input  tcdm_meta_t           req_meta_i,
  // Response port
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output logic [31:0]          rsp_rdata_o,
  output tcdm_meta_t           rsp_meta_o
);

  localparam int unsigned NumWords = 2 ** AddrWidth;

  // ------------------------------------------------
  // Internal wiring
  // ------------------------------------------------
  logic                 meta_push, meta_valid;
  logic                 rdata_push, rdata_valid, rdata_full, rdata_empty;
  logic [31:0]          rdata_in;
  logic                 pop;
  logic                 mem_req, mem_write;
  logic [AddrWidth-1:0] mem_addr;
  logic [31:0]          mem_wdata, mem_rdata;
  logic [3:0]           mem_be;

  tcdm_adapter #(
    .AddrWidth   (AddrWidth),
    .RegisterAmo (RegisterAmo),
    .LrScEnable  (LrScEnable)
  ) i_tcdm_adapter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_addr_i    (req_addr_i),
    .req_amo_i     (req_amo_i),
    .req_write_i   (req_write_i),
    .req_wdata_i   (req_wdata_i),
    .req_be_i      (req_be_i),
    .req_meta_i    (req_meta_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .meta_push_o   (meta_push),
    .meta_valid_i  (meta_valid),
    .rdata_push_o  (rdata_push),
    .rdata_o       (rdata_in),
    .rdata_valid_i (rdata_valid),
    .rdata_full_i  (rdata_full),
    .rdata_empty_i (rdata_empty),
    .pop_o         (pop),
    .mem_req_o     (mem_req),
    .mem_write_o   (mem_write),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_be_o      (mem_be),
    .mem_rdata_i   (mem_rdata)
  );

  // Metadata queued at acceptance
  resp_fifo #(
    .T (tcdm_meta_t)
  ) i_meta_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (meta_push),
    .data_i  (req_meta_i),
    .pop_i   (pop),
    .data_o  (rsp_meta_o),
    .valid_o (meta_valid),
    .full_o  (),
    .empty_o ()
  );

  // Read data queued a cycle later
  resp_fifo #(
    .T (logic [31:0])
  ) i_rdata_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rdata_push),
    .data_i  (rdata_in),
    .pop_i   (pop),
    .data_o  (rsp_rdata_o),
    .valid_o (rdata_valid),
    .full_o  (rdata_full),
    .empty_o (rdata_empty)
  );

  sram_bank #(
    .NumWords (NumWords)
  ) i_sram_bank (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .write_i (mem_write),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: src/tcdm_pkg.sv
`default_nettype none

// Types shared across the TCDM bank
package tcdm_pkg;

  // ------------------------------------------------
  // Core identity
  // ------------------------------------------------
  localparam int unsigned NumCores    = 16;
  localparam int unsigned CoreIdWidth = $clog2(NumCores);

  typedef logic [CoreIdWidth-1:0] core_id_t;

  // ------------------------------------------------
  // Response metadata, returned untouched
  // ------------------------------------------------
  typedef struct packed {
    core_id_t   core_id;
    logic [7:0] tag;
  } tcdm_meta_t;

endpackage

`default_nettype wire

// File: verification/tcdm_bank_ref.svh
`ifndef TCDM_BANK_REF_SVH
`define TCDM_BANK_REF_SVH

// ------------------------------------------------
// Shadow state of the bank
// ------------------------------------------------
logic [31:0]          shadow_mem [NumWords];
logic                 shadow_res_valid;
logic [AddrWidth-1:0] shadow_res_addr;
core_id_t             shadow_res_core;

// Memory starts cleared, no reservation held
task automatic clear_ref();
  for (int i = 0; i < NumWords; i++) begin
    shadow_mem[i] = 32'd0;
  end
  shadow_res_valid = 1'b0;
endtask

// Byte lanes with enable set take the new data
function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                            logic [3:0] be);
  logic [31:0] res;
  res = old_w;
  for (int b = 0; b < 4; b++) begin
    if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
  end
  return res;
endfunction

// New memory word after an atomic, per the RISC-V A extension
function automatic logic [31:0] amo_value(amo_op_t op, logic [31:0] old_w, logic [31:0] opnd);
  case (op)
    AmoSwap: return opnd;
    AmoAdd:  return old_w + opnd;
    AmoAnd:  return old_w & opnd;
    AmoOr:   return old_w | opnd;
    AmoXor:  return old_w ^ opnd;
    AmoMax:  return ($signed(old_w) > $signed(opnd)) ? old_w : opnd;
    AmoMaxu: return (old_w > opnd) ? old_w : opnd;
    AmoMin:  return ($signed(old_w) < $signed(opnd)) ? old_w : opnd;
    AmoMinu: return (old_w < opnd) ? old_w : opnd;
    default: return 32'd0;
  endcase
endfunction

// Expected read data of one accepted request, then shadow update
function automatic logic [31:0] expected_rsp(logic [AddrWidth-1:0] addr, amo_op_t op,
                                             logic write, logic [31:0] wdata,
                                             logic [3:0] be, core_id_t core);
  logic [31:0] old_w;
  logic [31:0] rsp;
  logic        own;
  logic        rmw;
  old_w = shadow_mem[addr];
  rsp   = old_w;
  own   = shadow_res_valid && (shadow_res_core == core);
  rmw   = (op >= AmoSwap) && (op <= AmoMinu);
  if (op == AmoLr) begin
    // Free slot or renewal by the owner
    if (!shadow_res_valid || own) begin
      shadow_res_valid = 1'b1;
      shadow_res_addr  = addr;
      shadow_res_core  = core;
    end
  end else if (op == AmoSc) begin
    rsp = 32'd1;
    if (own) begin
      shadow_res_valid = 1'b0;
      if (shadow_res_addr == addr) begin
        rsp              = 32'd0;
        shadow_mem[addr] = merge_bytes(old_w, wdata, be);
      end
    end
  end else begin
    // Another core touching the reserved word breaks the reservation
    if (shadow_res_valid && !own && (shadow_res_addr == addr) && (rmw || write)) begin
      shadow_res_valid = 1'b0;
    end
    if (rmw) shadow_mem[addr] = amo_value(op, old_w, wdata);
    else if (write) shadow_mem[addr] = merge_bytes(old_w, wdata, be);
  end
  return rsp;
endfunction

`endif

// File: verification/tcdm_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_tb
  import tcdm_pkg::*;
  import amo_pkg::*;
();

  localparam int unsigned AddrWidth    = 10;
  localparam bit          RegisterAmo  = 1'b0;
  localparam int unsigned NumWords     = 2 ** AddrWidth;
  // Test lengths, in requests
  localparam int unsigned NumFill      = 16;
  localparam int unsigned NumAmoRounds = 4;
  localparam int unsigned NumBp        = 40;
  localparam int unsigned NumMix       = 400;
  localparam int unsigned NumReqs      = 2 * NumFill + 3 * 9 * NumAmoRounds + 9 + NumBp + NumMix;
  localparam int unsigned TimeoutCycles = 20 * NumReqs + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  logic [AddrWidth-1:0] req_addr;
  amo_op_t              req_amo;
  logic                 req_write;
  logic [31:0]          req_wdata;
  logic [3:0]           req_be;
  tcdm_meta_t           req_meta;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [31:0]          rsp_rdata;
  tcdm_meta_t           rsp_meta;

  // Scoreboard
  logic [31:0] exp_rdata_q [$];
  tcdm_meta_t  exp_meta_q [$];
  int          errors;
  int          checks;
  int          req_count;
  int          rsp_count;
  int          cycles;
  logic [7:0]  tag_cnt;
  // Response ready shaping
  logic        bp_mode;
  int unsigned ready_pct;

  `include "tcdm_bank_ref.svh"

  tcdm_bank_top #(
    .AddrWidth   (AddrWidth),
    .RegisterAmo (RegisterAmo),
    .LrScEnable  (1'b1)
  ) i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_addr_i  (req_addr),
    .req_amo_i   (req_amo),
    .req_write_i (req_write),
    .req_wdata_i (req_wdata),
    .req_be_i    (req_be),
    .req_meta_i  (req_meta),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_o (rsp_rdata),
    .rsp_meta_o  (rsp_meta)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------
  // Request driving, called on a falling edge
  // ------------------------------------------------
  task automatic send_req(input logic [AddrWidth-1:0] addr, input amo_op_t op,
                          input logic write, input logic [31:0] wdata,
                          input logic [3:0] be, input core_id_t core);
    tcdm_meta_t meta;
    meta.core_id = core;
    meta.tag     = tag_cnt;
    req_addr     = addr;
    req_amo      = op;
    req_write    = write;
    req_wdata    = wdata;
    req_be       = be;
    req_meta     = meta;
    req_valid    = 1'b1;
    // Fields stay put until the bank takes them
    while (!req_ready) @(negedge clk);
    exp_rdata_q.push_back(expected_rsp(addr, op, write, wdata, be, core));
    exp_meta_q.push_back(meta);
    tag_cnt++;
    req_count++;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] addr, input logic [31:0] data,
                            input logic [3:0] be, input core_id_t core);
    send_req(addr, AmoNone, 1'b1, data, be, core);
  endtask

  task automatic read_word(input logic [AddrWidth-1:0] addr, input core_id_t core);
    send_req(addr, AmoNone, 1'b0, 32'd0, 4'hF, core);
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  // Values around the sign boundary, taken in pairs
  function automatic logic [31:0] edge_value(int unsigned idx);
    case (idx)
      0:       return 32'h8000_0000;
      1:       return 32'h7FFF_FFFF;
      2:       return 32'hFFFF_FFFF;
      default: return 32'h0000_0000;
    endcase
  endfunction

  // ------------------------------------------------
  // Response ready
  // ------------------------------------------------
  initial begin : drive_rsp_ready
    int unsigned hold;
    hold = 0;
    forever begin
      @(negedge clk);
      if (bp_mode) begin
        // Long high and low stretches
        if (hold == 0) begin
          rsp_ready = !rsp_ready;
          hold      = $urandom_range(6, 1);
        end else begin
          hold--;
        end
      end else begin
        rsp_ready = (($urandom % 100) < ready_pct);
      end
    end
  end

  // ------------------------------------------------
  // Compare, sampled mid-cycle once inputs have settled
  // ------------------------------------------------
  initial begin : compare_rsp
    logic [31:0] exp_data;
    tcdm_meta_t  exp_meta;
    logic        stalled;
    stalled = 1'b0;
    forever begin
      @(negedge clk);
      #1;
      if (rst_n) begin
        if (stalled && req_ready) begin
          $display("req_ready_o high while a response is waiting, cycle %0d", cycles);
          errors++;
        end
        if (rsp_valid && rsp_ready) begin
          rsp_count++;
          if (exp_rdata_q.size() == 0) begin
            $display("Response with no outstanding request, cycle %0d", cycles);
            errors++;
          end else begin
            exp_data = exp_rdata_q.pop_front();
            exp_meta = exp_meta_q.pop_front();
            checks++;
            if (rsp_rdata !== exp_data) begin
              $display("ERROR rsp_rdata_o got %h exp %h", rsp_rdata, exp_data);
              errors++;
            end
            if (rsp_meta !== exp_meta) begin
              $display("ERROR rsp_meta_o got %h exp %h", rsp_meta, exp_meta);
              errors++;
            end
          end
        end
        stalled = rsp_valid && !rsp_ready;
      end
    end
  end

  // Watchdog
  initial begin : watchdog
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d responses outstanding", cycles,
             exp_rdata_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin : stimulus
    logic [AddrWidth-1:0] a;
    logic [31:0]          v0;
    logic [31:0]          v1;
    core_id_t             c;
    int unsigned          k;
    void'($urandom(79));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_amo   = AmoNone;
    req_write = 1'b0;
    req_wdata = 32'd0;
    req_be    = 4'h0;
    req_meta  = '0;
    rsp_ready = 1'b1;
    bp_mode   = 1'b0;
    ready_pct = 100;
    errors    = 0;
    checks    = 0;
    req_count = 0;
    rsp_count = 0;
    tag_cnt   = 8'd0;
    clear_ref();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Byte-enabled stores, then read back
    for (int i = 0; i < NumFill; i++) begin
      write_word(i, $urandom, 4'($urandom), 2'($urandom));
    end
    for (int i = 0; i < NumFill; i++) begin
      read_word(i, 2'($urandom));
    end

    // Every RMW op, first rounds pair words across the sign boundary
    c = 4'd2;
    for (int r = 0; r < NumAmoRounds; r++) begin
      for (int j = 1; j <= 9; j++) begin
        a  = 32 + j;
        v0 = (r < 2) ? edge_value(2 * r) : $urandom;
        v1 = (r < 2) ? edge_value(2 * r + 1) : $urandom;
        write_word(a, v0, 4'hF, c);
        send_req(a, amo_op_t'(j), 1'b0, v1, 4'hF, c);
        read_word(a, c);
      end
    end

    // LR then SC by the same core
    send_req(64, AmoLr, 1'b0, 32'd0, 4'hF, 4'd1);
    send_req(64, AmoSc, 1'b0, 32'hCAFE_0001, 4'hF, 4'd1);
    read_word(64, 4'd1);
    // Store from core 2 breaks core 1's reservation
    send_req(65, AmoLr, 1'b0, 32'd0, 4'hF, 4'd1);
    write_word(65, 32'h1234_5678, 4'hF, 4'd2);
    send_req(65, AmoSc, 1'b0, 32'hCAFE_0002, 4'hF, 4'd1);
    read_word(65, 4'd1);
    // No reservation at all
    send_req(66, AmoSc, 1'b0, 32'hCAFE_0003, 4'hF, 4'd3);
    read_word(66, 4'd3);

    // Back-pressure on the response side
    bp_mode = 1'b1;
    for (int i = 0; i < NumBp; i++) begin
      if ($urandom % 2) write_word($urandom % 16, $urandom, 4'($urandom), 2'($urandom));
      else read_word($urandom % 16, 2'($urandom));
    end
    bp_mode = 1'b0;

    // Random mix from four cores on a few words
    ready_pct = 70;
    for (int i = 0; i < NumMix; i++) begin
      a = $urandom % 8;
      c = $urandom % 4;
      k = $urandom % 16;
      if (k < 4) read_word(a, c);
      else if (k < 7) write_word(a, $urandom, 4'($urandom), c);
      else if (k < 9) send_req(a, AmoLr, 1'b0, 32'd0, 4'hF, c);
      else if (k < 11) send_req(a, AmoSc, 1'b0, $urandom, 4'hF, c);
      else send_req(a, amo_op_t'($urandom_range(9, 1)), 1'b0, $urandom, 4'hF, c);
      if (($urandom % 10) < 3) idle($urandom_range(3, 1));
    end

    // Drain, then watch for stray responses
    ready_pct = 100;
    while (exp_rdata_q.size() != 0) @(negedge clk);
    idle(5);
    if (rsp_count != req_count) begin
      $display("Sent %0d requests but got %0d responses", req_count, rsp_count);
      errors++;
    end
    $display("Requests %0d, responses %0d, checks %0d, errors %0d",
             req_count, rsp_count, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
